/* include/vector_reduction_settings.svh */
`ifndef VECTOR_REDUCTION_SETTINGS_SVH
`define VECTOR_REDUCTION_SETTINGS_SVH

// Vector register width
`define VR_VLEN 64

// Scalar seed and result width
`define VR_XLEN 32

// Element count at 8-bit width
`define VR_MAX_ELEMS 8

// Vector length field width
`define VR_VL_W 4

`endif

/* design/vector_reduction_pkg.sv */
`include "vector_reduction_settings.svh"

package vector_reduction_pkg;

    typedef logic [`VR_VLEN-1:0]      vreg_t;
    typedef logic [`VR_XLEN-1:0]      scalar_t;
    typedef logic [`VR_MAX_ELEMS-1:0] elem_mask_t;
    typedef logic [`VR_VL_W-1:0]      vl_t;

    // One extended lane per element position
    typedef logic [`VR_MAX_ELEMS-1:0][`VR_XLEN-1:0] lanes_t;

    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } sew_e;

    typedef enum logic [2:0] {
        VREDSUM  = 3'd0,
        VREDAND  = 3'd1,
        VREDOR   = 3'd2,
        VREDXOR  = 3'd3,
        VREDMIN  = 3'd4,
        VREDMINU = 3'd5,
        VREDMAX  = 3'd6,
        VREDMAXU = 3'd7
    } red_op_e;

    // ******************************
    // Reduction helpers
    // ******************************

    // Identities hold in the extended lane domain for every element width
    function automatic scalar_t red_identity(input red_op_e op);
        case (op)
            VREDAND, VREDMINU: return '1;
            VREDMIN:           return {1'b0, {(`VR_XLEN-1){1'b1}}};
            VREDMAX:           return {1'b1, {(`VR_XLEN-1){1'b0}}};
            default:           return '0;
        endcase
    endfunction

    function automatic scalar_t red_combine(input red_op_e op, input scalar_t a,
                                            input scalar_t b);
        case (op)
            VREDSUM:  return a + b;
            VREDAND:  return a & b;
            VREDOR:   return a | b;
            VREDXOR:  return a ^ b;
            VREDMIN:  return ($signed(a) < $signed(b)) ? a : b;
            VREDMINU: return (a < b) ? a : b;
            VREDMAX:  return ($signed(a) > $signed(b)) ? a : b;
            default:  return (a > b) ? a : b;
        endcase
    endfunction

    // Balanced pairwise tree, seed joins at the root
    function automatic scalar_t red_fold(input red_op_e op, input lanes_t lanes,
                                         input elem_mask_t act, input scalar_t seed);
        lanes_t acc;
        for (int i = 0; i < `VR_MAX_ELEMS; i++) begin
            acc[i] = act[i] ? lanes[i] : red_identity(op);
        end
        for (int step = 1; step < `VR_MAX_ELEMS; step = step * 2) begin
            for (int i = 0; i < `VR_MAX_ELEMS; i = i + 2 * step) begin
                acc[i] = red_combine(op, acc[i], acc[i+step]);
            end
        end
        return red_combine(op, seed, acc[0]);
    endfunction

    // Truncate to the element width, then zero-extend
    function automatic scalar_t pick_width(input sew_e sew, input scalar_t r8,
                                           input scalar_t r16, input scalar_t r32);
        case (sew)
            EW8:     return {{(`VR_XLEN-8){1'b0}}, r8[7:0]};
            EW16:    return {{(`VR_XLEN-16){1'b0}}, r16[15:0]};
            default: return r32;
        endcase
    endfunction

endpackage

/* design/red_operand_if.sv */
interface red_operand_if;
    import vector_reduction_pkg::*;

    // Vector operand and seed
    vreg_t      vreg;
    scalar_t    scalar;
    sew_e       sew;

    // Agreed set of active element positions
    elem_mask_t active;

    modport producer (
        output vreg,
        output scalar,
        output sew,
        output active
    );

    modport consumer (
        input vreg,
        input scalar,
        input sew,
        input active
    );

endinterface

/* design/red_result_if.sv */
interface red_result_if;
    import vector_reduction_pkg::*;

    scalar_t red_sum;
    scalar_t red_and;
    scalar_t red_or;
    scalar_t red_xor;
    scalar_t red_min;
    scalar_t red_minu;
    scalar_t red_max;
    scalar_t red_maxu;

    modport arith (
        output red_sum, red_min, red_minu, red_max, red_maxu
    );

    modport logical (
        output red_and, red_or, red_xor
    );

    modport select (
        input red_sum, red_and, red_or, red_xor,
        input red_min, red_minu, red_max, red_maxu
    );

endinterface

/* design/red_element_mask.sv */
`include "vector_reduction_settings.svh"

module red_element_mask (
    input  vector_reduction_pkg::sew_e       sew_i,
    input  vector_reduction_pkg::vreg_t      vreg_i,
    input  vector_reduction_pkg::scalar_t    scalar_i,
    input  vector_reduction_pkg::vl_t        vl_i,
    input  logic                             vm_i,
    input  vector_reduction_pkg::elem_mask_t mask_i,
    red_operand_if.producer                  opnd
);
    import vector_reduction_pkg::*;

    vl_t elem_limit;
    vl_t eff_vl;

    // Element count at the current width
    always_comb begin
        case (sew_i)
            EW8:     elem_limit = vl_t'(`VR_MAX_ELEMS);
            EW16:    elem_limit = vl_t'(`VR_MAX_ELEMS / 2);
            default: elem_limit = vl_t'(`VR_MAX_ELEMS / 4);
        endcase
    end

    // Long vector lengths take every element
    assign eff_vl = (vl_i > elem_limit) ? elem_limit : vl_i;

    always_comb begin
        for (int i = 0; i < `VR_MAX_ELEMS; i++) begin
            opnd.active[i] = (vl_t'(i) < eff_vl) && (vm_i || mask_i[i]);
        end
    end

    assign opnd.vreg   = vreg_i;
    assign opnd.scalar = scalar_i;
    assign opnd.sew    = sew_i;

endmodule

/* design/red_arith_tree.sv */
`include "vector_reduction_settings.svh"

module red_arith_tree (
    red_operand_if.consumer opnd,
    red_result_if.arith     res
);
    import vector_reduction_pkg::*;

    // Per-width results, index 0/1/2 for 8/16/32 bits
    scalar_t sum_w  [3];
    scalar_t min_w  [3];
    scalar_t minu_w [3];
    scalar_t max_w  [3];
    scalar_t maxu_w [3];

    // ******************************
    // Element split per width
    // ******************************
    for (genvar g = 0; g < 3; g++) begin : g_width
        localparam int EW = 8 << g;
        localparam int NE = `VR_MAX_ELEMS >> g;

        lanes_t     lane_z;
        lanes_t     lane_s;
        elem_mask_t act;
        scalar_t    seed_z;
        scalar_t    seed_s;

        // Signed ops see sign-extended lanes, the rest zero-extended
        always_comb begin
            lane_z = '0;
            lane_s = '0;
            act    = '0;
            for (int i = 0; i < NE; i++) begin
                lane_z[i] = scalar_t'(opnd.vreg[i*EW +: EW]);
                lane_s[i] = scalar_t'($signed(opnd.vreg[i*EW +: EW]));
                act[i]    = opnd.active[i];
            end
        end

        assign seed_z = scalar_t'(opnd.scalar[EW-1:0]);
        assign seed_s = scalar_t'($signed(opnd.scalar[EW-1:0]));

        assign sum_w[g]  = red_fold(VREDSUM,  lane_z, act, seed_z);
        assign min_w[g]  = red_fold(VREDMIN,  lane_s, act, seed_s);
        assign minu_w[g] = red_fold(VREDMINU, lane_z, act, seed_z);
        assign max_w[g]  = red_fold(VREDMAX,  lane_s, act, seed_s);
        assign maxu_w[g] = red_fold(VREDMAXU, lane_z, act, seed_z);
    end

    // ******************************
    // Width select
    // ******************************
    assign res.red_sum  = pick_width(opnd.sew, sum_w[0], sum_w[1], sum_w[2]);
    assign res.red_min  = pick_width(opnd.sew, min_w[0], min_w[1], min_w[2]);
    assign res.red_minu = pick_width(opnd.sew, minu_w[0], minu_w[1], minu_w[2]);
    assign res.red_max  = pick_width(opnd.sew, max_w[0], max_w[1], max_w[2]);
    assign res.red_maxu = pick_width(opnd.sew, maxu_w[0], maxu_w[1], maxu_w[2]);

endmodule

/* design/red_logic_tree.sv */
`include "vector_reduction_settings.svh"

module red_logic_tree (
    red_operand_if.consumer opnd,
    red_result_if.logical   res
);
    import vector_reduction_pkg::*;

    scalar_t and_w [3];
    scalar_t or_w  [3];
    scalar_t xor_w [3];

    // ******************************
    // Element split per width
    // ******************************
    for (genvar g = 0; g < 3; g++) begin : g_width
        localparam int EW = 8 << g;
        localparam int NE = `VR_MAX_ELEMS >> g;

        lanes_t     lane_z;
        elem_mask_t act;
        scalar_t    seed_z;

        // Bitwise ops only need zero-extended lanes
        always_comb begin
            lane_z = '0;
            act    = '0;
            for (int i = 0; i < NE; i++) begin
                lane_z[i] = scalar_t'(opnd.vreg[i*EW +: EW]);
                act[i]    = opnd.active[i];
            end
        end

        assign seed_z = scalar_t'(opnd.scalar[EW-1:0]);

        assign and_w[g] = red_fold(VREDAND, lane_z, act, seed_z);
        assign or_w[g]  = red_fold(VREDOR,  lane_z, act, seed_z);
        assign xor_w[g] = red_fold(VREDXOR, lane_z, act, seed_z);
    end

    // All-ones identity is trimmed back to the element width here
    assign res.red_and = pick_width(opnd.sew, and_w[0], and_w[1], and_w[2]);
    assign res.red_or  = pick_width(opnd.sew, or_w[0], or_w[1], or_w[2]);
    assign res.red_xor = pick_width(opnd.sew, xor_w[0], xor_w[1], xor_w[2]);

endmodule

/* design/red_result_select.sv */
module red_result_select (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             enable_i,
    input  vector_reduction_pkg::red_op_e    op_i,
    red_result_if.select                     res,
    output vector_reduction_pkg::scalar_t    result_o,
    output logic                             valid_o
);
    import vector_reduction_pkg::*;

    scalar_t result_sel;

    // Operation mux, and as the fallback
    always_comb begin
        case (op_i)
            VREDSUM:  result_sel = res.red_sum;
            VREDOR:   result_sel = res.red_or;
            VREDXOR:  result_sel = res.red_xor;
            VREDMIN:  result_sel = res.red_min;
            VREDMINU: result_sel = res.red_minu;
            VREDMAX:  result_sel = res.red_max;
            VREDMAXU: result_sel = res.red_maxu;
            default:  result_sel = res.red_and;
        endcase
    end

    // ******************************
    // Output register
    // ******************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
            valid_o  <= 1'b0;
        end else begin
            // One pulse per enable
            valid_o <= enable_i;
            if (enable_i) begin
                result_o <= result_sel;
            end
        end
    end

endmodule

/* design/vector_reduction.sv */
module vector_reduction (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             enable_i,
    input  vector_reduction_pkg::red_op_e    op_i,
    input  vector_reduction_pkg::sew_e       sew_i,
    input  vector_reduction_pkg::vreg_t      vreg_i,
    input  vector_reduction_pkg::scalar_t    scalar_i,
    input  vector_reduction_pkg::vl_t        vl_i,
    input  logic                             vm_i,
    input  vector_reduction_pkg::elem_mask_t mask_i,
    output vector_reduction_pkg::scalar_t    result_o,
    output logic                             valid_o
);

    red_operand_if opnd_if ();
    red_result_if  res_if ();

    // ******************************
    // Operand qualification
    // ******************************
    red_element_mask element_mask_inst (
        .sew_i    (sew_i),
        .vreg_i   (vreg_i),
        .scalar_i (scalar_i),
        .vl_i     (vl_i),
        .vm_i     (vm_i),
        .mask_i   (mask_i),
        .opnd     (opnd_if.producer)
    );

    // ******************************
    // Reduction trees
    // ******************************
    red_arith_tree arith_tree_inst (
        .opnd (opnd_if.consumer),
        .res  (res_if.arith)
    );

    red_logic_tree logic_tree_inst (
        .opnd (opnd_if.consumer),
        .res  (res_if.logical)
    );

    // Registered result with valid pulse
    red_result_select result_select_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .op_i     (op_i),
        .res      (res_if.select),
        .result_o (result_o),
        .valid_o  (valid_o)
    );

endmodule

/* testbench/tb_vector_reduction.sv */
module tb_vector_reduction;
    timeunit 1ns;
    timeprecision 100ps;
    import vector_reduction_pkg::*;

    localparam int SUM_ITEMS    = 3 * 8;
    localparam int LOGIC_ITEMS  = 3 * 3 * 4;
    localparam int MINMAX_ITEMS = 4 * 3 * 4;
    localparam int VL_ITEMS     = 3 * 8;
    localparam int B2B_CYCLES   = 12 + 3 + 5 + 5;
    localparam int ITEM_CYCLES  = 2 * (SUM_ITEMS + LOGIC_ITEMS + MINMAX_ITEMS + VL_ITEMS);
    localparam int TEST_CYCLES  = 8 + 4 + ITEM_CYCLES + B2B_CYCLES + 6 * 6;
    localparam int WATCHDOG_NS  = TEST_CYCLES * 10 + 500;

    logic       clk;
    logic       reset_n;
    logic       enable_i;
    red_op_e    op_i;
    sew_e       sew_i;
    vreg_t      vreg_i;
    scalar_t    scalar_i;
    vl_t        vl_i;
    logic       vm_i;
    elem_mask_t mask_i;
    scalar_t    result_o;
    logic       valid_o;

    integer     seed = 32'h72b8;
    int         errors = 0;
    int         errors_at_start = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    scalar_t    exp_q[$];
    scalar_t    last_result = '0;
    logic       exp_valid = 1'b0;

    sew_e       widths[3] = '{EW8, EW16, EW32};
    red_op_e    logic_ops[3] = '{VREDAND, VREDOR, VREDXOR};
    red_op_e    minmax_ops[4] = '{VREDMIN, VREDMINU, VREDMAX, VREDMAXU};

    vector_reduction vector_reduction_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .op_i     (op_i),
        .sew_i    (sew_i),
        .vreg_i   (vreg_i),
        .scalar_i (scalar_i),
        .vl_i     (vl_i),
        .vm_i     (vm_i),
        .mask_i   (mask_i),
        .result_o (result_o),
        .valid_o  (valid_o)
    );

    always #5 clk = ~clk;

    // ******************************
    // Reference model
    // ******************************
    function automatic int elem_bits(input sew_e sew);
        case (sew)
            EW8:     return 8;
            EW16:    return 16;
            default: return 32;
        endcase
    endfunction

    function automatic longint to_signed(input longint x, input int ew);
        return x - ((x >> (ew - 1)) << ew);
    endfunction

    // Inactive elements skipped since their identity changes nothing
    function automatic scalar_t model_reduce(input red_op_e op, input sew_e sew,
                                             input vreg_t v, input scalar_t s, input vl_t vl,
                                             input logic vm, input elem_mask_t m);
        int     ew;
        longint mask_w;
        longint acc;
        longint e;
        ew     = elem_bits(sew);
        mask_w = (longint'(1) << ew) - 1;
        acc    = longint'(s) & mask_w;
        for (int i = 0; i < 64 / ew; i++) begin
            if (i < int'(vl) && (vm || m[i])) begin
                e = longint'(v >> (i * ew)) & mask_w;
                case (op)
                    VREDSUM:  acc = (acc + e) & mask_w;
                    VREDAND:  acc = acc & e;
                    VREDOR:   acc = acc | e;
                    VREDXOR:  acc = acc ^ e;
                    VREDMIN:  acc = (to_signed(e, ew) < to_signed(acc, ew)) ? e : acc;
                    VREDMINU: acc = (e < acc) ? e : acc;
                    VREDMAX:  acc = (to_signed(e, ew) > to_signed(acc, ew)) ? e : acc;
                    default:  acc = (e > acc) ? e : acc;
                endcase
            end
        end
        return scalar_t'(acc);
    endfunction

    // ******************************
    // Stimulus helpers
    // ******************************
    function automatic vreg_t rand_vreg();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic red_op_e rand_op();
        logic [31:0] r;
        r = $random(seed);
        return red_op_e'(r[2:0]);
    endfunction

    function automatic vl_t elem_count(input sew_e sew);
        return vl_t'(64 / elem_bits(sew));
    endfunction

    // Mix of zero, all ones, signed min, signed max and random elements
    function automatic vreg_t extreme_vreg(input sew_e sew);
        vreg_t  v;
        int     ew;
        longint mask_w;
        longint pat;
        logic [31:0] r;
        ew     = elem_bits(sew);
        mask_w = (longint'(1) << ew) - 1;
        v      = rand_vreg();
        for (int i = 0; i < 64 / ew; i++) begin
            r = $unsigned($random(seed)) % 32'd6;
            case (r)
                0:       pat = 0;
                1:       pat = mask_w;
                2:       pat = longint'(1) << (ew - 1);
                3:       pat = mask_w >> 1;
                default: pat = longint'(v >> (i * ew)) & mask_w;
            endcase
            v = (v & ~(vreg_t'(mask_w) << (i * ew))) | (vreg_t'(pat) << (i * ew));
        end
        return v;
    endfunction

    task automatic issue(input red_op_e op, input sew_e sew, input vreg_t v,
                         input scalar_t s, input vl_t vl, input logic vm,
                         input elem_mask_t m);
        @(posedge clk);
        enable_i <= 1'b1;
        op_i     <= op;
        sew_i    <= sew;
        vreg_i   <= v;
        scalar_i <= s;
        vl_i     <= vl;
        vm_i     <= vm;
        mask_i   <= m;
        exp_q.push_back(model_reduce(op, sew, v, s, vl, vm, m));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            enable_i <= 1'b0;
        end
    endtask

    // ******************************
    // Checks
    // ******************************
    task automatic check_result(input scalar_t got, input scalar_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: result_o = 0x%08h, expected 0x%08h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: valid_o = %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        exp_valid <= reset_n && enable_i;
    end

    // Result holds between valid pulses
    always @(negedge clk) begin
        check_valid(valid_o, exp_valid);
        if (valid_o === 1'b1 && exp_q.size() > 0) begin
            last_result = exp_q.pop_front();
        end
        check_result(result_o, last_result);
    end

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() > 0 && waited < 4) begin
            idle(1);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Test %s: valid_o never came for %0d request(s)", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        if (errors == errors_at_start) begin
            $display("Test %s: pass", name);
            tests_passed++;
        end else begin
            $display("Test %s: fail, %0d error(s)", name, errors - errors_at_start);
            tests_failed++;
        end
        errors_at_start = errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        reset_n  = 1'b0;
        enable_i = 1'b0;
        op_i     = VREDSUM;
        sew_i    = EW8;
        vreg_i   = '0;
        scalar_i = '0;
        vl_i     = '0;
        vm_i     = 1'b0;
        mask_i   = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        idle(4);
        end_test("reset state");

        foreach (widths[w]) begin
            for (int k = 0; k < 8; k++) begin
                issue(VREDSUM, widths[w], rand_vreg(), $random(seed),
                      elem_count(widths[w]), 1'b1, '1);
                idle(1);
            end
        end
        end_test("sum");

        foreach (logic_ops[o]) begin
            foreach (widths[w]) begin
                for (int k = 0; k < 4; k++) begin
                    issue(logic_ops[o], widths[w], rand_vreg(), $random(seed),
                          elem_count(widths[w]), 1'b0, elem_mask_t'($random(seed)));
                    idle(1);
                end
            end
        end
        end_test("and/or/xor masked");

        foreach (minmax_ops[o]) begin
            foreach (widths[w]) begin
                for (int k = 0; k < 4; k++) begin
                    issue(minmax_ops[o], widths[w], extreme_vreg(widths[w]),
                          scalar_t'(extreme_vreg(EW32)), elem_count(widths[w]), 1'b1, '1);
                    idle(1);
                end
            end
        end
        end_test("min/max extremes");

        // Zero length gives the seed alone
        // Lengths 9 to 15 take every element
        foreach (widths[w]) begin
            for (int k = 0; k < 8; k++) begin
                issue(rand_op(), widths[w], rand_vreg(), $random(seed),
                      (k < 4) ? vl_t'(0) : vl_t'(2 * k + 1), 1'b1, '1);
                idle(1);
            end
        end
        end_test("vector length limits");

        for (int k = 0; k < 17; k++) begin
            issue(rand_op(), widths[k % 3], rand_vreg(), $random(seed),
                  vl_t'($random(seed)), k[0], elem_mask_t'($random(seed)));
            if (k == 11) begin
                idle(3);
            end
        end
        idle(5);
        end_test("back-to-back");

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vector_reduction.f */
+incdir+include
design/vector_reduction_pkg.sv
design/red_operand_if.sv
design/red_result_if.sv
design/red_element_mask.sv
design/red_arith_tree.sv
design/red_logic_tree.sv
design/red_result_select.sv
design/vector_reduction.sv
testbench/tb_vector_reduction.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector reduction testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_vector_reduction -f vector_reduction.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_vector_reduction > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
